// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // addi x0,x0,0, fills every empty slot
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // major opcode of jal
    localparam logic [6:0] opc_jal = 7'b110_1111;

    // request half of the instruction bus, core to memory
    typedef struct packed {
        logic            req;  // request strobe
        logic [xlen-1:0] addr; // word address
    } mem_req_t;

    // response half, memory to core
    typedef struct packed {
        logic            gnt;    // request taken this cycle
        logic            rvalid; // rdata valid, in order
        logic [xlen-1:0] rdata;
    } mem_rsp_t;

    // fetch to decode payload
    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;    // address the word came from
    } fetch_out_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [6:0]      opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [2:0]      funct3;
        logic [xlen-1:0] imm;    // j-type for jal, i-type otherwise
    } decoded_t;

    typedef struct packed {
        logic            taken;  // one cycle pulse
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: logic/pc_gen.sv
`default_nettype none

module pc_gen (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fetch_stall_i, // offered pc not accepted
    input  fetch_pkg::redirect_t       redirect_i,
    output logic [fetch_pkg::xlen-1:0] pc_o           // always offered to fetch
);
    import fetch_pkg::*;

    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_d;
    logic [xlen-1:0] pc_seq; // next word in memory order

    assign pc_seq = pc_q + xlen'(4);

    // redirect wins over a normal step
    always_comb begin
        if (redirect_i.taken) begin
            pc_d = redirect_i.target;
        end else if (!fetch_stall_i) begin
            pc_d = pc_seq; // fetch took this pc
        end else begin
            pc_d = pc_q;   // hold until granted
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= pc_d;
        end
    end

    // valid is implied, the register always holds the next address to fetch
    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: logic/ins_fetch.sv
`default_nettype none

module ins_fetch (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [fetch_pkg::xlen-1:0] pc_i,           // next address from pc_gen
    input  logic                       exec_stall_i,   // execute not taking
    input  fetch_pkg::redirect_t       redirect_i,     // taken doubles as abort
    input  fetch_pkg::mem_rsp_t        mem_rsp_i,
    output fetch_pkg::mem_req_t        mem_req_o,
    output logic                       fetch_stall_o,  // pc not accepted this cycle
    output logic                       decode_stall_o, // waiting for rvalid
    output logic                       ins_valid_o,
    output fetch_pkg::fetch_out_t      ins_o
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE         = 2'b00, // nothing in flight, may issue
        S_WAIT_GNT     = 2'b01, // request up, memory has not granted
        S_WAIT_RVALID  = 2'b10, // one granted request in flight
        S_ABORT_RVALID = 2'b11  // in flight but redirected, data dropped
    } state_e;

    state_e          state_q;
    state_e          state_d;
    state_e          issue_state;    // where an issued request leads

    logic [xlen-1:0] pc_req_q;       // pc of the granted request
    logic            backup_valid_q; // word saved under exec stall
    fetch_out_t      backup_q;

    logic            abort;
    logic            can_issue;
    logic            issue_slot;     // state allows a new request
    logic            issue;
    logic            accept;         // req and gnt together
    logic            rsp_live;       // response that is kept
    logic            save;           // response parked in the backup
    logic            replay;         // backup goes to decode

    assign abort     = redirect_i.taken;
    assign can_issue = !exec_stall_i && !abort; // pc_i is stale during a redirect

    // a new request may overlap the rvalid cycle of the previous one
    always_comb begin
        case (state_q)
            S_IDLE,
            S_WAIT_GNT:     issue_slot = 1'b1;
            S_WAIT_RVALID,
            S_ABORT_RVALID: issue_slot = mem_rsp_i.rvalid;
            default:        issue_slot = 1'b0;
        endcase
    end

    assign issue  = issue_slot && can_issue;
    assign accept = issue && mem_rsp_i.gnt;

    assign rsp_live = (state_q == S_WAIT_RVALID) && mem_rsp_i.rvalid && !abort;
    assign save     = rsp_live && exec_stall_i;
    assign replay   = backup_valid_q && !exec_stall_i;

    // request straight from pc_i, addr held by pc_gen while not granted
    assign mem_req_o.req  = issue;
    assign mem_req_o.addr = pc_i;

    assign fetch_stall_o  = !accept;
    assign decode_stall_o = (state_q == S_WAIT_RVALID) && !mem_rsp_i.rvalid && !abort;

    // backup replays first, live data next, nop otherwise
    assign ins_valid_o = replay || (rsp_live && !exec_stall_i);

    always_comb begin
        if (backup_valid_q) begin
            ins_o = backup_q;
        end else if (rsp_live) begin
            ins_o = '{instr: mem_rsp_i.rdata, pc: pc_req_q};
        end else begin
            ins_o = '{instr: nop_instr, pc: pc_req_q};
        end
    end

    assign issue_state = mem_rsp_i.gnt ? S_WAIT_RVALID : S_WAIT_GNT;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (issue) begin
                    state_d = issue_state;
                end
            end
            S_WAIT_GNT: begin
                if (issue) begin
                    state_d = issue_state;
                end else if (abort) begin
                    state_d = S_IDLE; // withdrawn, nothing in flight
                end
                // under exec stall the request is dropped but the state kept
            end
            S_WAIT_RVALID: begin
                if (mem_rsp_i.rvalid) begin
                    state_d = issue ? issue_state : S_IDLE; // abort here just drops rdata
                end else if (abort) begin
                    state_d = S_ABORT_RVALID;
                end
            end
            S_ABORT_RVALID: begin
                if (mem_rsp_i.rvalid) begin
                    state_d = issue ? issue_state : S_IDLE; // late word thrown away
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q        <= S_IDLE;
            backup_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (save) begin
                backup_valid_q <= 1'b1;
            end else if (replay) begin
                backup_valid_q <= 1'b0; // consumed by decode this cycle
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_req_q <= pc_i; // pairs the response with its address
        end
        if (save) begin
            backup_q <= '{instr: mem_rsp_i.rdata, pc: pc_req_q};
        end
    end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exec_stall_i,   // hold the register
    input  logic                  decode_stall_i, // fetch still waiting for rvalid
    input  logic                  ins_valid_i,
    input  fetch_pkg::fetch_out_t ins_i,
    output fetch_pkg::decoded_t   dec_o,
    output fetch_pkg::redirect_t  redirect_o
);
    import fetch_pkg::*;

    fetch_out_t      word_q;
    logic            valid_q;
    logic            fresh_q; // captured at the last edge
    logic            take;
    logic [6:0]      opcode;
    logic            is_jal;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_j;

    // nothing is taken while a redirect is out, that word is off-path
    assign take = ins_valid_i && !decode_stall_i && !redirect_o.taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            fresh_q <= 1'b0;
        end else if (!exec_stall_i) begin
            valid_q <= take;
            fresh_q <= take;
        end else begin
            fresh_q <= 1'b0; // held word raises no second redirect
        end
    end

    // bubble shows a nop
    always_ff @(posedge clk) begin
        if (!exec_stall_i) begin
            if (take) begin
                word_q <= ins_i;
            end else begin
                word_q <= '{instr: nop_instr, pc: ins_i.pc};
            end
        end
    end

    assign opcode = word_q.instr[6:0];
    assign is_jal = (opcode == opc_jal);

    assign imm_i = {{20{word_q.instr[31]}}, word_q.instr[31:20]};
    // j-type, scrambled bits put back in order
    assign imm_j = {{12{word_q.instr[31]}},
                    word_q.instr[19:12],
                    word_q.instr[20],
                    word_q.instr[30:21],
                    1'b0};

    assign dec_o.valid  = valid_q;
    assign dec_o.pc     = word_q.pc;
    assign dec_o.opcode = opcode;
    assign dec_o.rd     = word_q.instr[11:7];
    assign dec_o.rs1    = word_q.instr[19:15];
    assign dec_o.funct3 = word_q.instr[14:12];
    assign dec_o.imm    = is_jal ? imm_j : imm_i;

    // first cycle of a fresh jal only
    assign redirect_o.taken  = fresh_q && is_jal;
    assign redirect_o.target = word_q.pc + imm_j;

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`default_nettype none

module fetch_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 exec_stall_i, // level from execute
    input  fetch_pkg::mem_rsp_t  mem_rsp_i,
    output fetch_pkg::mem_req_t  mem_req_o,
    output fetch_pkg::decoded_t  dec_o,
    output fetch_pkg::redirect_t redirect_o    // also fed back to pc_gen and fetch
);
    import fetch_pkg::*;

    logic [xlen-1:0] pc;           // pc_gen to fetch
    logic            fetch_stall;
    logic            decode_stall;
    logic            ins_valid;
    fetch_out_t      ins;          // fetch to decode

    // producer
    pc_gen u_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .fetch_stall_i (fetch_stall),
        .redirect_i    (redirect_o),
        .pc_o          (pc)
    );

    // buffer on the memory bus
    ins_fetch u_ins_fetch (
        .clk            (clk),
        .reset          (reset),
        .pc_i           (pc),
        .exec_stall_i   (exec_stall_i),
        .redirect_i     (redirect_o),
        .mem_rsp_i      (mem_rsp_i),
        .mem_req_o      (mem_req_o),
        .fetch_stall_o  (fetch_stall),
        .decode_stall_o (decode_stall),
        .ins_valid_o    (ins_valid),
        .ins_o          (ins)
    );

    // consumer, source of the jal redirect
    decode_stage u_decode_stage (
        .clk            (clk),
        .reset          (reset),
        .exec_stall_i   (exec_stall_i),
        .decode_stall_i (decode_stall),
        .ins_valid_i    (ins_valid),
        .ins_i          (ins),
        .dec_o          (dec_o),
        .redirect_o     (redirect_o)
    );

endmodule

`default_nettype wire

// File: verif/mem_model.sv
`default_nettype none

module mem_model (
    input  logic                clk,
    input  logic                reset,
    input  fetch_pkg::mem_req_t mem_req_i,
    input  logic [2:0]          gnt_delay_i,    // cycles req waits before gnt
    input  logic [2:0]          rvalid_delay_i, // accept to rvalid, 1 or more
    output fetch_pkg::mem_rsp_t mem_rsp_o,
    output int                  error_count_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    logic [2:0]      gnt_wait;  // cycles req has been up without gnt
    logic            pending;   // accepted, rvalid still owed
    logic [2:0]      rsp_wait;
    logic [xlen-1:0] rsp_addr;
    logic            wait_q;    // req was waiting last cycle
    logic [xlen-1:0] wait_addr;
    logic            accept;
    logic            rvalid;
    int              errors = 0;

    function automatic logic [xlen-1:0] jal_word(input logic [xlen-1:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, opc_jal}; // jal x0
    endfunction

    // addi with rd from A[6:2] and imm from A[13:2], two jumps patched in
    function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] a);
        if (a == 32'h40) begin
            return jal_word(32'h100 - a);
        end else if (a == 32'h140) begin
            return jal_word(32'h20 - a); // loop back
        end else begin
            return {a[13:2], 5'd0, 3'd0, a[6:2], 7'b001_0011};
        end
    endfunction

    assign rvalid           = pending && (rsp_wait == 3'd0);
    assign mem_rsp_o.gnt    = mem_req_i.req && (gnt_wait >= gnt_delay_i);
    assign mem_rsp_o.rvalid = rvalid;
    assign mem_rsp_o.rdata  = rvalid ? word_at(rsp_addr) : '0;
    assign accept           = mem_req_i.req && mem_rsp_o.gnt;
    assign error_count_o    = errors;

    always @(posedge clk) begin
        if (reset) begin
            gnt_wait <= '0;
            pending  <= 1'b0;
            rsp_wait <= '0;
            wait_q   <= 1'b0;
        end else begin
            gnt_wait  <= (mem_req_i.req && !mem_rsp_o.gnt) ? gnt_wait + 3'd1 : 3'd0;
            wait_q    <= mem_req_i.req && !mem_rsp_o.gnt;
            wait_addr <= mem_req_i.addr;
            // a waiting request may be withdrawn but not moved
            if (wait_q && mem_req_i.req && (mem_req_i.addr != wait_addr)) begin
                errors = errors + 1;
                $display("memory: address moved from %h to %h before grant",
                         wait_addr, mem_req_i.addr);
            end
            if (accept) begin
                if (pending && !rvalid) begin
                    errors = errors + 1;
                    $display("memory: request for %h accepted while %h still has no response",
                             mem_req_i.addr, rsp_addr);
                end
                pending  <= 1'b1;
                rsp_addr <= mem_req_i.addr;
                rsp_wait <= rvalid_delay_i - 3'd1;
            end else if (rvalid) begin
                pending <= 1'b0; // response given, bus free
            end else if (pending) begin
                rsp_wait <= rsp_wait - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_fetch_top.sv
`default_nettype none

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam int n_rows    = 6;
    localparam int stall_len = 16; // stall pattern repeats with this period

    typedef struct packed {
        logic [2:0]  gnt;
        logic [2:0]  rvalid;
        logic        rnd_stall; // pattern drawn at start
        logic [15:0] stall;
        logic [7:0]  count;     // decoded words to check
    } row_t;

    logic            clk = 1'b0;
    logic            reset;
    logic            exec_stall;
    logic [2:0]      gnt_delay;
    logic [2:0]      rvalid_delay;
    mem_req_t        mem_req;
    mem_rsp_t        mem_rsp;
    decoded_t        dec;
    redirect_t       redirect;
    int              mem_errors;
    row_t            rows [n_rows];
    int              errors   = 0;
    int              cycles   = 0;
    int              limit    = 0;
    int              row_idx  = 0;
    int              seen;            // words checked in this row
    logic            checking = 1'b0;
    logic            prev_stall;
    decoded_t        prev_dec;
    logic [xlen-1:0] walk_pc;         // reference pc walk

    always #50 clk = ~clk;

    fetch_top u_fetch_top (
        .clk          (clk),
        .reset        (reset),
        .exec_stall_i (exec_stall),
        .mem_rsp_i    (mem_rsp),
        .mem_req_o    (mem_req),
        .dec_o        (dec),
        .redirect_o   (redirect)
    );

    mem_model u_mem_model (
        .clk            (clk),
        .reset          (reset),
        .mem_req_i      (mem_req),
        .gnt_delay_i    (gnt_delay),
        .rvalid_delay_i (rvalid_delay),
        .mem_rsp_o      (mem_rsp),
        .error_count_o  (mem_errors)
    );

    function automatic logic is_jal_at(input logic [xlen-1:0] pc);
        return (pc == 32'h40) || (pc == 32'h140);
    endfunction

    function automatic logic [xlen-1:0] jal_target(input logic [xlen-1:0] pc);
        return (pc == 32'h40) ? 32'h100 : 32'h20;
    endfunction

    function automatic logic [xlen-1:0] next_pc(input logic [xlen-1:0] pc);
        return is_jal_at(pc) ? jal_target(pc) : pc + 32'd4;
    endfunction

    // fields per the contents rule and the rv32i formats
    function automatic decoded_t expected_decoded(input logic [xlen-1:0] pc);
        decoded_t        d;
        logic [xlen-1:0] off;
        off     = jal_target(pc) - pc;
        d.valid = 1'b1;
        d.pc    = pc;
        if (is_jal_at(pc)) begin
            d.opcode = opc_jal;
            d.rd     = 5'd0;
            d.rs1    = off[19:15]; // immediate bits sit in the rs1 slot
            d.funct3 = off[14:12];
            d.imm    = off;
        end else begin
            d.opcode = 7'b001_0011; // op-imm
            d.rd     = pc[6:2];
            d.rs1    = 5'd0;
            d.funct3 = 3'd0;
            d.imm    = {{20{pc[13]}}, pc[13:2]};
        end
        return d;
    endfunction

    task automatic check_decoded(input decoded_t exp, input decoded_t got, input string name);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_redirect(input redirect_t exp, input redirect_t got);
        if ((got.taken !== exp.taken) || (exp.taken && (got.target !== exp.target))) begin
            errors++;
            $display("Mismatch at %0d ns: redirect_o expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d memory protocol", errors, mem_errors);
    endtask

    // sampled mid cycle, inputs move on the rising edge
    always @(negedge clk) begin
        redirect_t exp_r;
        if (checking) begin
            exp_r = '0; // no pulse unless a fresh jal shows
            if (prev_stall) begin
                check_decoded(prev_dec, dec, "dec_o held");
            end else if (dec.valid) begin
                check_decoded(expected_decoded(walk_pc), dec, "dec_o");
                exp_r.taken  = is_jal_at(walk_pc);
                exp_r.target = jal_target(walk_pc);
                walk_pc      = next_pc(walk_pc);
                seen++;
            end
            check_redirect(exp_r, redirect);
            prev_stall = exec_stall;
            prev_dec   = dec;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: row %0d had %0d words checked when the limit of %0d cycles ran out",
                     row_idx, seen, limit);
            print_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        row_t r;
        int   cyc;
        void'($urandom(64436));
        reset        = 1'b1;
        exec_stall   = 1'b0;
        gnt_delay    = 3'd0;
        rvalid_delay = 3'd1;
        prev_stall   = 1'b0;
        seen         = 0;
        walk_pc      = reset_pc;
        // gnt, rvalid, random stall, stall pattern, words
        rows = '{
            '{3'd0, 3'd1, 1'b0, 16'h0000, 8'd44}, // zero wait
            '{3'd1, 3'd2, 1'b0, 16'h0000, 8'd40},
            '{3'd3, 3'd4, 1'b0, 16'h0000, 8'd40},
            '{3'd2, 3'd1, 1'b0, 16'h00f0, 8'd40}, // fixed stall burst
            '{3'd0, 3'd1, 1'b1, 16'h0000, 8'd44},
            '{3'd0, 3'd3, 1'b1, 16'h0000, 8'd44}
        };
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].rnd_stall) begin
                rows[i].stall = 16'($urandom & $urandom) & 16'h7fff; // bit 15 low, fetch moves
            end
            limit += 40 * int'(rows[i].count) + 8;
        end
        for (int i = 0; i < n_rows; i++) begin
            row_idx = i;
            r       = rows[i];
            @(posedge clk);
            reset        <= 1'b1;
            exec_stall   <= 1'b0;
            gnt_delay    <= r.gnt;
            rvalid_delay <= r.rvalid;
            repeat (8) @(posedge clk);
            reset      <= 1'b0;
            walk_pc    = reset_pc;
            seen       = 0;
            prev_stall = 1'b0;
            checking   = 1'b1;
            cyc        = 0;
            while (seen < int'(r.count)) begin
                exec_stall <= r.stall[cyc % stall_len];
                cyc++;
                @(posedge clk);
            end
            checking = 1'b0;
        end
        print_counts();
        if ((errors == 0) && (mem_errors == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/ins_fetch.sv
logic/decode_stage.sv
logic/fetch_top.sv
verif/mem_model.sv
verif/tb_fetch_top.sv

// File: Makefile
TOP = tb_fetch_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

lint:
	verilator --lint-only -Wall --timing --top-module fetch_top -f sources.f

clean:
	rm -rf obj_dir
